//--- rtl/benes.sv
`timescale 1ns/10ps

`include "xbar_cfg.svh"

module benes
    import xbar_pkg::*;
(
    input logic  CLK,
    input logic  nRST,
    xbar_if.xbar xif
);

    localparam int SIZE   = `XBAR_SIZE;
    localparam int DWIDTH = `XBAR_DWIDTH;
    localparam int HALF   = SIZE / 2;

    localparam logic [STAGES-2:0] REG_MASK = `XBAR_REG_MASK;

    // Lanes into and out of each stage, with the valid and control riding along.
    logic [DWIDTH-1:0]    stg_in   [STAGES][SIZE];
    logic [DWIDTH-1:0]    stg_out  [STAGES][SIZE];
    logic                 stg_vld  [STAGES];
    logic [CTRL_BITS-1:0] stg_ctrl [STAGES];

    assign stg_in[0]   = xif.in;
    assign stg_vld[0]  = xif.in_valid;
    assign stg_ctrl[0] = xif.ctrl;

    // ========================================================================
    // Stage boundaries
    // ========================================================================

    for (genvar b = 0; b < STAGES - 1; b++) begin : g_bound
        // Slices below LO belong to stages already passed.
        localparam int LO = (b + 1) * HALF;

        if (REG_MASK[b]) begin : g_reg
            logic [DWIDTH-1:0]     data_q [SIZE];
            logic                  vld_q;
            logic [CTRL_BITS-1:LO] ctrl_q;

            always_ff @(posedge CLK, negedge nRST) begin
                if (!nRST) begin
                    vld_q  <= 1'b0;
                    ctrl_q <= '0;
                    for (int i = 0; i < SIZE; i++) begin
                        data_q[i] <= '0;
                    end
                end else begin
                    vld_q  <= stg_vld[b];
                    ctrl_q <= stg_ctrl[b][CTRL_BITS-1:LO];
                    data_q <= stg_out[b];
                end
            end

            assign stg_in[b+1]   = data_q;
            assign stg_vld[b+1]  = vld_q;
            assign stg_ctrl[b+1] = {ctrl_q, {LO{1'b0}}};
        end else begin : g_comb
            assign stg_in[b+1]   = stg_out[b];
            assign stg_vld[b+1]  = stg_vld[b];
            assign stg_ctrl[b+1] = stg_ctrl[b];
        end
    end

    // ========================================================================
    // Switch stages
    // ========================================================================

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        if (s == 0) begin : g_first
            for (genvar k = 0; k < HALF; k++) begin : g_sw
                crossover_switch #(.WIDTH(DWIDTH)) u_sw (
                    .din  ({stg_in[0][2*k], stg_in[0][2*k+1]}),
                    .cntrl(stg_ctrl[0][k]),
                    .dout ({stg_out[0][2*k], stg_out[0][2*k+1]})
                );
            end
        end else if (s == STAGES - 1) begin : g_last
            for (genvar k = 0; k < HALF; k++) begin : g_sw
                crossover_switch #(.WIDTH(DWIDTH)) u_sw (
                    .din  ({stg_in[s][2*k], stg_in[s][2*k+1]}),
                    .cntrl(stg_ctrl[s][HALF*s + k]),
                    .dout ({stg_out[s][2*k], stg_out[s][2*k+1]})
                );
            end
        end else begin : g_mid
            // Pair distance grows to the centre, then shrinks again.
            localparam int D = (s < TAGWIDTH) ? (1 << s) : (1 << (STAGES - 1 - s));

            for (genvar g = 0; g < HALF / D; g++) begin : g_grp
                for (genvar j = 0; j < D; j++) begin : g_sw
                    localparam int IDX = g * 2 * D + j;
                    localparam int CB  = IDX + HALF * s - D * g;

                    crossover_switch #(.WIDTH(DWIDTH)) u_sw (
                        .din  ({stg_in[s][IDX], stg_in[s][IDX+D]}),
                        .cntrl(stg_ctrl[s][CB]),
                        .dout ({stg_out[s][IDX], stg_out[s][IDX+D]})
                    );
                end
            end
        end
    end

    // Last stage is combinational onto the outputs.
    assign xif.out       = stg_out[STAGES-1];
    assign xif.out_valid = stg_vld[STAGES-1];

endmodule

//--- rtl/benes_ctrl_regs.sv
`timescale 1ns/10ps

`include "xbar_cfg.svh"

module benes_ctrl_regs
    import xbar_pkg::*;
(
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       cfg_strobe,
    input  cfg_op_t                    cfg_op,
    input  logic [1:0]                 cfg_addr,
    input  logic [`XBAR_CFG_WIDTH-1:0] cfg_wdata,
    output logic [CTRL_BITS-1:0]       ctrl
);

    localparam int WORD = `XBAR_CFG_WIDTH;

    logic [CFG_WORDS*WORD-1:0] shadow;
    logic [CTRL_BITS-1:0]      active;
    logic                      addr_ok;
    logic                      do_write;
    logic                      do_clear;
    logic                      do_commit;

    // ========================================================================
    // Opcode decode
    // ========================================================================

    assign addr_ok = int'(cfg_addr) < CFG_WORDS;

    always_comb begin
        do_write  = 1'b0;
        do_clear  = 1'b0;
        do_commit = 1'b0;
        if (cfg_strobe) begin
            case (cfg_op)
                CFG_NOP:    ;
                CFG_WRITE:  do_write  = addr_ok;
                CFG_CLEAR:  do_clear  = 1'b1;
                CFG_COMMIT: do_commit = 1'b1;
                default:    ;
            endcase
        end
    end

    // ========================================================================
    // Shadow and active registers
    // ========================================================================

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            shadow <= '0;
        end else if (do_clear) begin
            shadow <= '0;
        end else if (do_write) begin
            shadow[cfg_addr*WORD +: WORD] <= cfg_wdata;
        end
    end

    // Padding bits of the last word are dropped.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active <= '0;
        end else if (do_commit) begin
            active <= shadow[CTRL_BITS-1:0];
        end
    end

    assign ctrl = active;

endmodule

//--- rtl/crossover_switch.sv
`timescale 1ns/10ps

module crossover_switch #(
    parameter int WIDTH = 16
) (
    input  logic [1:0][WIDTH-1:0] din,
    input  logic                  cntrl,
    output logic [1:0][WIDTH-1:0] dout
);

    // Straight when low, exchanged when high.
    always_comb begin
        if (cntrl) begin
            dout[0] = din[1];
            dout[1] = din[0];
        end else begin
            dout = din;
        end
    end

endmodule

//--- rtl/xbar_cfg.svh
`ifndef XBAR_CFG_SVH
`define XBAR_CFG_SVH

// ============================================================================
// Crossbar network sizing
// ============================================================================

// Power of two lane count.
`define XBAR_SIZE 8

// Bits per lane.
`define XBAR_DWIDTH 16

// One bit per stage boundary. A set bit puts a register after that stage.
`define XBAR_REG_MASK 4'b1111

// Configuration data word.
`define XBAR_CFG_WIDTH 8

`endif

//--- rtl/xbar_if.sv
`timescale 1ns/10ps

`include "xbar_cfg.svh"

interface xbar_if
    import xbar_pkg::*;
();

    // Input side.
    logic                     in_valid;
    logic [`XBAR_DWIDTH-1:0]  in [`XBAR_SIZE];

    // Active switch settings, sampled with every accepted item.
    logic [CTRL_BITS-1:0]     ctrl;

    // Output side.
    logic                     out_valid;
    logic [`XBAR_DWIDTH-1:0]  out [`XBAR_SIZE];

    modport xbar (
        input  in_valid, in, ctrl,
        output out_valid, out
    );

    modport src (
        output in_valid, in, ctrl,
        input  out_valid, out
    );

endinterface

//--- rtl/xbar_pkg.sv
`include "xbar_cfg.svh"

package xbar_pkg;

    // Switch address bits per lane.
    localparam int TAGWIDTH = $clog2(`XBAR_SIZE);

    // Benes depth for a power of two lane count.
    localparam int STAGES = (2 * TAGWIDTH) - 1;

    // One control bit per switch, SIZE/2 switches per stage.
    localparam int CTRL_BITS = STAGES * (`XBAR_SIZE / 2);

    // Configuration words needed to cover every control bit.
    localparam int CFG_WORDS = (CTRL_BITS + `XBAR_CFG_WIDTH - 1) / `XBAR_CFG_WIDTH;

    // Configuration port opcodes.
    typedef enum logic [1:0] {
        CFG_NOP    = 2'd0,
        CFG_WRITE  = 2'd1,
        CFG_CLEAR  = 2'd2,
        CFG_COMMIT = 2'd3
    } cfg_op_t;

endpackage

//--- rtl/xbar_top.sv
`timescale 1ns/10ps

`include "xbar_cfg.svh"

module xbar_top
    import xbar_pkg::*;
(
    input  logic                                  CLK,
    input  logic                                  nRST,

    // Data in with lane 0 in the low bits.
    input  logic                                  in_valid,
    input  logic [`XBAR_SIZE*`XBAR_DWIDTH-1:0]    in_data,

    // Configuration port.
    input  logic                                  cfg_strobe,
    input  cfg_op_t                               cfg_op,
    input  logic [1:0]                            cfg_addr,
    input  logic [`XBAR_CFG_WIDTH-1:0]            cfg_wdata,

    // Data out.
    output logic                                  out_valid,
    output logic [`XBAR_SIZE*`XBAR_DWIDTH-1:0]    out_data
);

    localparam int SIZE   = `XBAR_SIZE;
    localparam int DWIDTH = `XBAR_DWIDTH;

    xbar_if xif ();

    assign xif.in_valid = in_valid;
    assign out_valid    = xif.out_valid;

    // Flat vectors to and from the lane arrays.
    for (genvar i = 0; i < SIZE; i++) begin : g_lane
        assign xif.in[i]                     = in_data[i*DWIDTH +: DWIDTH];
        assign out_data[i*DWIDTH +: DWIDTH]  = xif.out[i];
    end

    benes_ctrl_regs u_ctrl (
        .CLK       (CLK),
        .nRST      (nRST),
        .cfg_strobe(cfg_strobe),
        .cfg_op    (cfg_op),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .ctrl      (xif.ctrl)
    );

    benes u_benes (
        .CLK (CLK),
        .nRST(nRST),
        .xif (xif.xbar)
    );

endmodule

//--- verification/xbar_sva.sv
`timescale 1ns/10ps

`include "xbar_cfg.svh"

module xbar_sva
    import xbar_pkg::*;
(
    input logic                               CLK,
    input logic                               nRST,
    input logic                               in_valid,
    input logic                               out_valid,
    input logic [`XBAR_SIZE*`XBAR_DWIDTH-1:0] out_data,
    input logic                               cfg_strobe,
    input cfg_op_t                            cfg_op,
    input logic [1:0]                         cfg_addr
);

    // One cycle per registered stage boundary.
    localparam int LAT = $countones(`XBAR_REG_MASK);

    a_out_follows_in: assert property (@(posedge CLK) disable iff (!nRST)
        in_valid |-> ##LAT out_valid)
        else $error("out_valid missing %0d cycles after in_valid", LAT);

    a_out_has_source: assert property (@(posedge CLK) disable iff (!nRST)
        out_valid |-> $past(in_valid, LAT))
        else $error("out_valid without a matching in_valid");

    a_out_known: assert property (@(posedge CLK) disable iff (!nRST)
        out_valid |-> !$isunknown(out_data))
        else $error("out_data has unknown bits while valid");

    a_cfg_addr_range: assert property (@(posedge CLK) disable iff (!nRST)
        (cfg_strobe && cfg_op == CFG_WRITE) |-> (int'(cfg_addr) < CFG_WORDS))
        else $error("configuration write to address %0d out of range", cfg_addr);

endmodule

bind xbar_top xbar_sva u_sva (
    .CLK       (CLK),
    .nRST      (nRST),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_data  (out_data),
    .cfg_strobe(cfg_strobe),
    .cfg_op    (cfg_op),
    .cfg_addr  (cfg_addr)
);

//--- verification/xbar_tb.sv
`timescale 1ns/10ps

`include "xbar_cfg.svh"

module xbar_tb
    import xbar_pkg::*;
();

    localparam int SIZE   = `XBAR_SIZE;
    localparam int DWIDTH = `XBAR_DWIDTH;
    localparam int HALF   = SIZE / 2;
    localparam int WORD   = `XBAR_CFG_WIDTH;
    localparam int FLAT   = SIZE * DWIDTH;

    typedef logic [SIZE-1:0][DWIDTH-1:0] lanes_t;
    typedef enum bit [1:0] {STEP_CFG, STEP_DATA, STEP_DATA_CFG} step_kind_t;

    typedef struct {
        string           name;
        step_kind_t      kind;
        cfg_op_t         op;
        logic [1:0]      addr;
        logic [WORD-1:0] word;
        bit              b2b;
    } step_t;

    typedef struct {
        string  name;
        lanes_t value;
    } exp_item_t;

    logic            CLK;
    logic            nRST;
    logic            in_valid;
    logic [FLAT-1:0] in_data;
    logic            cfg_strobe;
    cfg_op_t         cfg_op;
    logic [1:0]      cfg_addr;
    logic [WORD-1:0] cfg_wdata;
    logic            out_valid;
    logic [FLAT-1:0] out_data;

    step_t                     steps[$];
    exp_item_t                 expected[$];
    logic [CFG_WORDS*WORD-1:0] shadow_m;
    logic [CTRL_BITS-1:0]      active_m;
    int                        sent;
    int                        seen;
    int                        cycles;
    int                        limit;

    xbar_top DUT (.*);

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    // ========================================================================
    // Helpers
    // ========================================================================

    task automatic check_value(string name, logic [FLAT-1:0] exp, logic [FLAT-1:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic void add_step(string name, step_kind_t kind, cfg_op_t op,
                                     logic [1:0] addr, logic [WORD-1:0] word, bit b2b);
        steps.push_back('{name, kind, op, addr, word, b2b});
    endfunction

    function automatic logic [WORD-1:0] rand_word();
        int unsigned r;
        r = $urandom;
        return r[WORD-1:0];
    endfunction

    // Expected lane order, stage by stage. First and last stage pair at distance 1.
    function automatic lanes_t route_lanes(lanes_t din, logic [CTRL_BITS-1:0] c);
        lanes_t            v;
        logic [DWIDTH-1:0] t;
        int                d;
        int                cb;
        v = din;
        for (int s = 0; s < STAGES; s++) begin
            if (s == 0 || s == STAGES - 1) d = 1;
            else if (s < TAGWIDTH) d = 1 << s;
            else d = 1 << (STAGES - 1 - s);
            for (int lo = 0; lo < SIZE; lo++) begin
                if ((lo / d) % 2 == 0) begin
                    cb = lo + HALF * s - d * (lo / (2 * d));
                    if (c[cb]) begin
                        t         = v[lo];
                        v[lo]     = v[lo + d];
                        v[lo + d] = t;
                    end
                end
            end
        end
        return v;
    endfunction

    function automatic void model_cfg(cfg_op_t op, logic [1:0] addr, logic [WORD-1:0] word);
        case (op)
            CFG_WRITE:  if (int'(addr) < CFG_WORDS) shadow_m[addr*WORD +: WORD] = word;
            CFG_CLEAR:  shadow_m = '0;
            CFG_COMMIT: active_m = shadow_m[CTRL_BITS-1:0];
            default:    ;
        endcase
    endfunction

    task automatic drive_idle();
        in_valid   = 1'b0;
        in_data    = '0;
        cfg_strobe = 1'b0;
        cfg_op     = CFG_NOP;
        cfg_addr   = '0;
        cfg_wdata  = '0;
    endtask

    task automatic issue_step(step_t st);
        lanes_t      data;
        int unsigned r;
        if (st.kind != STEP_CFG) begin
            for (int l = 0; l < SIZE; l++) begin
                r       = $urandom;
                data[l] = r[DWIDTH-1:0];
            end
            in_valid = 1'b1;
            in_data  = data;
            // Item takes the routing active before this edge.
            expected.push_back('{st.name, route_lanes(data, active_m)});
            sent++;
        end
        if (st.kind != STEP_DATA) begin
            cfg_strobe = 1'b1;
            cfg_op     = st.op;
            cfg_addr   = st.addr;
            cfg_wdata  = st.word;
            model_cfg(st.op, st.addr, st.word);
        end
    endtask

    // ========================================================================
    // Output monitor and cycle limit
    // ========================================================================

    always @(posedge CLK) begin : monitor
        exp_item_t item;
        if (out_valid) begin
            if (expected.size() == 0) begin
                $display("TEST FAILED");
                $display("out_valid seen with no item pending");
                $fatal(1);
            end else begin
                item = expected.pop_front();
                check_value(item.name, item.value, out_data);
                seen++;
            end
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("TEST FAILED");
            $display("Timeout: outputs stalled after %0d cycles", cycles);
            $fatal(1);
        end
    end

    // ========================================================================
    // Stimulus table and main sequence
    // ========================================================================

    initial begin
        sent     = 0;
        seen     = 0;
        cycles   = 0;
        limit    = 0;
        shadow_m = '0;
        active_m = '0;
        nRST     = 1'b0;
        drive_idle();
        void'($urandom(87));

        add_step("reset_identity", STEP_DATA, CFG_NOP,    2'd0, 8'h00, 1'b0);
        add_step("sw_stage0",      STEP_CFG,  CFG_WRITE,  2'd0, 8'h01, 1'b1);
        add_step("sw_stage0",      STEP_CFG,  CFG_COMMIT, 2'd0, 8'h00, 1'b1);
        add_step("sw_stage0",      STEP_DATA, CFG_NOP,    2'd0, 8'h00, 1'b0);
        add_step("sw_middle",      STEP_CFG,  CFG_CLEAR,  2'd0, 8'h00, 1'b1);
        add_step("sw_middle",      STEP_CFG,  CFG_WRITE,  2'd1, 8'h04, 1'b1);
        add_step("sw_middle",      STEP_CFG,  CFG_COMMIT, 2'd0, 8'h00, 1'b1);
        add_step("sw_middle",      STEP_DATA, CFG_NOP,    2'd0, 8'h00, 1'b0);
        add_step("sw_last",        STEP_CFG,  CFG_CLEAR,  2'd0, 8'h00, 1'b1);
        add_step("sw_last",        STEP_CFG,  CFG_WRITE,  2'd2, 8'h01, 1'b1);
        add_step("sw_last",        STEP_CFG,  CFG_COMMIT, 2'd0, 8'h00, 1'b1);
        add_step("sw_last",        STEP_DATA, CFG_NOP,    2'd0, 8'h00, 1'b0);
        for (int a = 0; a < CFG_WORDS; a++) begin
            add_step("full_cfg", STEP_CFG, CFG_WRITE, 2'(a), rand_word(), 1'b1);
        end
        add_step("full_cfg",       STEP_CFG,  CFG_COMMIT, 2'd0, 8'h00, 1'b1);
        add_step("full_cfg",       STEP_DATA, CFG_NOP,    2'd0, 8'h00, 1'b1);
        add_step("full_cfg",       STEP_DATA, CFG_NOP,    2'd0, 8'h00, 1'b1);
        add_step("full_cfg",       STEP_DATA, CFG_NOP,    2'd0, 8'h00, 1'b0);
        add_step("shadow_write",   STEP_CFG,  CFG_WRITE,  2'd0, rand_word(), 1'b1);
        add_step("shadow_write",   STEP_DATA, CFG_NOP,    2'd0, 8'h00, 1'b0);
        add_step("shadow_clear",   STEP_CFG,  CFG_CLEAR,  2'd0, 8'h00, 1'b1);
        add_step("shadow_clear",   STEP_DATA, CFG_NOP,    2'd0, 8'h00, 1'b0);
        add_step("shadow_commit",  STEP_CFG,  CFG_WRITE,  2'd1, rand_word() | 8'h01, 1'b1);
        add_step("shadow_commit",  STEP_CFG,  CFG_COMMIT, 2'd0, 8'h00, 1'b1);
        add_step("shadow_commit",  STEP_DATA, CFG_NOP,    2'd0, 8'h00, 1'b0);
        for (int a = 0; a < CFG_WORDS; a++) begin
            add_step("inflight_cfg", STEP_CFG, CFG_WRITE, 2'(a), rand_word(), 1'b1);
        end
        add_step("inflight_old",   STEP_DATA,     CFG_NOP,    2'd0, 8'h00, 1'b1);
        add_step("inflight_edge",  STEP_DATA_CFG, CFG_COMMIT, 2'd0, 8'h00, 1'b1);
        add_step("inflight_new",   STEP_DATA,     CFG_NOP,    2'd0, 8'h00, 1'b1);
        add_step("inflight_new",   STEP_DATA,     CFG_NOP,    2'd0, 8'h00, 1'b0);

        limit = steps.size() * 8 + 50;

        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        repeat (2) @(negedge CLK);
        check_value("reset_idle", '0, FLAT'(out_valid));

        foreach (steps[i]) begin
            @(negedge CLK);
            drive_idle();
            issue_step(steps[i]);
            if (!steps[i].b2b) begin
                @(negedge CLK);
                drive_idle();
                while (expected.size() != 0) @(negedge CLK);
            end
        end
        @(negedge CLK);
        drive_idle();
        while (expected.size() != 0) @(negedge CLK);

        check_value("item_count", FLAT'(sent), FLAT'(seen));
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/xbar_pkg.sv
rtl/xbar_if.sv
rtl/crossover_switch.sv
rtl/benes.sv
rtl/benes_ctrl_regs.sv
rtl/xbar_top.sv
verification/xbar_sva.sv
verification/xbar_tb.sv
